// File: verilog/vsmem_pkg.sv
// Shared sizes, encodings and payload types for the fetch/data memory subsystem

package vsmem_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Memory depth in 64-bit blocks
    localparam int MEM_BLOCKS = 32;
    // Cycles from req first seen to ack
    localparam int MEM_LATENCY = 3;
    // Byte address width
    localparam int ADDR_W = 8;
    // Block index is the address without its 3 byte-offset bits
    localparam int BLOCK_IDX_W = 5;

    typedef logic [ADDR_W-1:0] addr_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_e;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } mem_cmd_e;

    // One memory block, seen as a double word or as two instructions
    // Word 0 sits at byte offset 0
    typedef union packed {
        logic [63:0]       double;
        logic [1:0][31:0]  words;
    } mem_block_u;

    ////////////////////////////////////////
    // Port payloads
    ////////////////////////////////////////

    // Load/store command from outside, store data right-aligned
    typedef struct packed {
        mem_cmd_e    cmd;
        mem_size_e   size;
        addr_t       addr;
        logic [63:0] data;
    } dmem_cmd_t;

    // Block-wide request toward memory
    typedef struct packed {
        logic                   write;
        logic [BLOCK_IDX_W-1:0] block_idx;
        mem_block_u             wdata;
        logic [7:0]             byte_en;
    } mem_req_t;

    // Instruction handed to decode
    typedef struct packed {
        logic        valid;
        addr_t       pc;
        logic [31:0] inst;
    } fetch_packet_t;

    // Taken-branch redirect
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

endpackage

// File: verilog/fetch_unit.sv
// Instruction fetch with a one-block buffer, redirect handling and a valid/ready output register
`timescale 1ns/100ps

module fetch_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  vsmem_pkg::redirect_t     redirect,
    output vsmem_pkg::fetch_packet_t fetch_out,
    input  logic                     fetch_ready,
    output logic                     fetch_req,
    output vsmem_pkg::mem_req_t      fetch_req_pl,
    input  logic                     fetch_ack,
    input  vsmem_pkg::mem_block_u    rdata
);

    // Program counter of the instruction to present next
    vsmem_pkg::addr_t pc;

    // Buffered block and its index
    vsmem_pkg::mem_block_u                  buf_block;
    logic [vsmem_pkg::BLOCK_IDX_W-1:0]      buf_idx;
    logic                                   buf_valid;
    logic                                   buf_hit;

    // Block index held stable for the running read
    logic [vsmem_pkg::BLOCK_IDX_W-1:0]      req_idx;
    // Set when a redirect overtakes a read in flight
    logic                                   drop;

    // Output register
    logic                                   out_valid;
    vsmem_pkg::addr_t                       out_pc;
    logic [31:0]                            out_inst;

    assign buf_hit = buf_valid && (buf_idx == pc[vsmem_pkg::ADDR_W-1:3]);

    assign fetch_out.valid = out_valid;
    assign fetch_out.pc    = out_pc;
    assign fetch_out.inst  = out_inst;

    // Read-only request for one block
    always_comb begin
        fetch_req_pl           = '0;
        fetch_req_pl.block_idx = req_idx;
    end

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc        <= '0;
            out_valid <= 1'b0;
            fetch_req <= 1'b0;
            buf_valid <= 1'b0;
            drop      <= 1'b0;
        end else begin
            // Read closes, keep the block unless it went stale
            if (fetch_req && fetch_ack) begin
                fetch_req <= 1'b0;
                drop      <= 1'b0;
                if (!drop && !redirect.valid) begin
                    buf_valid <= 1'b1;
                end
            end
            if (redirect.valid) begin
                // Flush output and buffer, refetch at target
                pc        <= redirect.target;
                out_valid <= 1'b0;
                buf_valid <= 1'b0;
                if (fetch_req && !fetch_ack) begin
                    drop <= 1'b1;
                end
            end else if (out_valid) begin
                // Hold under back-pressure
                if (fetch_ready) begin
                    out_valid <= 1'b0;
                    pc        <= pc + vsmem_pkg::addr_t'(4);
                end
            end else if (buf_hit) begin
                out_valid <= 1'b1;
            end else if (!fetch_req && !fetch_ack) begin
                // Miss, previous handshake fully closed
                fetch_req <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Payload
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!fetch_req) begin
            req_idx <= pc[vsmem_pkg::ADDR_W-1:3];
        end
        if (fetch_req && fetch_ack) begin
            buf_block <= rdata;
            buf_idx   <= req_idx;
        end
        // Word select by PC bit 2
        if (!out_valid && !redirect.valid && buf_hit) begin
            out_pc   <= pc;
            out_inst <= buf_block.words[pc[2]];
        end
    end

endmodule

// File: verilog/data_port.sv
// Load/store port, sized commands turned into block-wide requests with byte-lane steering
`timescale 1ns/100ps

module data_port (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dreq,
    input  vsmem_pkg::dmem_cmd_t  dcmd,
    output logic                  dack,
    output logic [63:0]           drdata,
    output logic                  data_req,
    output vsmem_pkg::mem_req_t   data_req_pl,
    input  logic                  data_ack,
    input  vsmem_pkg::mem_block_u rdata
);

    typedef enum logic [1:0] {
        D_IDLE = 2'd0,
        D_REQ  = 2'd1,
        D_DONE = 2'd2
    } dstate_e;

    dstate_e              state;
    // Command held for the whole transaction
    vsmem_pkg::dmem_cmd_t cmd_q;

    vsmem_pkg::addr_t     aligned;
    logic [2:0]           byte_off;
    logic [5:0]           bit_shift;
    logic [7:0]           size_be;
    logic [63:0]          size_mask;
    logic [63:0]          load_data;

    ////////////////////////////////////////
    // Lane steering
    ////////////////////////////////////////

    // Address truncated to the natural alignment of the size
    always_comb begin
        case (cmd_q.size)
            vsmem_pkg::BYTE: begin
                aligned   = cmd_q.addr;
                size_be   = 8'h01;
                size_mask = 64'h0000_0000_0000_00ff;
            end
            vsmem_pkg::HALF: begin
                aligned   = cmd_q.addr & ~vsmem_pkg::addr_t'(1);
                size_be   = 8'h03;
                size_mask = 64'h0000_0000_0000_ffff;
            end
            vsmem_pkg::WORD: begin
                aligned   = cmd_q.addr & ~vsmem_pkg::addr_t'(3);
                size_be   = 8'h0f;
                size_mask = 64'h0000_0000_ffff_ffff;
            end
            default: begin
                aligned   = cmd_q.addr & ~vsmem_pkg::addr_t'(7);
                size_be   = 8'hff;
                size_mask = 64'hffff_ffff_ffff_ffff;
            end
        endcase
        byte_off  = aligned[2:0];
        bit_shift = {byte_off, 3'b000};
    end

    always_comb begin
        data_req_pl              = '0;
        data_req_pl.write        = (cmd_q.cmd == vsmem_pkg::STORE);
        data_req_pl.block_idx    = aligned[vsmem_pkg::ADDR_W-1:3];
        data_req_pl.wdata.double = (cmd_q.data & size_mask) << bit_shift;
        // Loads touch no lanes
        if (cmd_q.cmd == vsmem_pkg::STORE) begin
            data_req_pl.byte_en = size_be << byte_off;
        end
    end

    // Field down to bit 0, zero above the size
    assign load_data = (rdata.double >> bit_shift) & size_mask;

    ////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= D_IDLE;
            data_req <= 1'b0;
            dack     <= 1'b0;
        end else begin
            case (state)
                D_IDLE: if (dreq) begin
                    data_req <= 1'b1;
                    state    <= D_REQ;
                end
                D_REQ: if (data_ack) begin
                    data_req <= 1'b0;
                    dack     <= 1'b1;
                    state    <= D_DONE;
                end
                // Both sides back to low before the next command
                D_DONE: if (!dreq && !data_ack) begin
                    dack  <= 1'b0;
                    state <= D_IDLE;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == D_IDLE && dreq) begin
            cmd_q <= dcmd;
        end
        if (state == D_REQ && data_ack) begin
            drdata <= load_data;
        end
    end

endmodule

// File: verilog/mem_arbiter.sv
// Two-client four-phase memory arbiter, data side first, grant held until the handshake closes
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                clock,
    input  logic                reset,
    // Instruction fetch client
    input  logic                fetch_req,
    input  vsmem_pkg::mem_req_t fetch_req_pl,
    output logic                fetch_ack,
    // Load/store client
    input  logic                data_req,
    input  vsmem_pkg::mem_req_t data_req_pl,
    output logic                data_ack,
    // Memory side
    output logic                mem_req,
    output vsmem_pkg::mem_req_t mem_req_pl,
    input  logic                mem_ack
);

    // Grant held and its owner
    logic grant_valid;
    // High when the data client owns the grant
    logic grant_data;
    // Request of the current owner
    logic sel_req;

    ////////////////////////////////////////
    // Routing
    ////////////////////////////////////////

    assign sel_req = grant_data ? data_req : fetch_req;

    // Request reaches memory only under a grant
    assign mem_req = grant_valid && sel_req;

    // Owner's payload, stable for as long as its req is high
    assign mem_req_pl = grant_data ? data_req_pl : fetch_req_pl;

    // Ack back to the owner only
    assign data_ack  = grant_valid && grant_data && mem_ack;
    assign fetch_ack = grant_valid && !grant_data && mem_ack;

    ////////////////////////////////////////
    // Grant
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            grant_valid <= 1'b0;
            grant_data  <= 1'b0;
        end else if (!grant_valid) begin
            // Data side wins a tie
            if (data_req) begin
                grant_valid <= 1'b1;
                grant_data  <= 1'b1;
            end else if (fetch_req) begin
                grant_valid <= 1'b1;
                grant_data  <= 1'b0;
            end
        end else if (!sel_req && !mem_ack) begin
            // Owner dropped req and memory dropped ack, so all four phases are done
            // An idle cycle follows before the next grant
            grant_valid <= 1'b0;
        end
    end

endmodule

// File: verilog/block_memory.sv
// Block-wide memory with byte enables and a fixed latency before acknowledge
`timescale 1ns/100ps

module block_memory (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  mem_req,
    input  vsmem_pkg::mem_req_t   mem_req_pl,
    output logic                  mem_ack,
    output vsmem_pkg::mem_block_u mem_rdata
);

    vsmem_pkg::mem_block_u mem_array [vsmem_pkg::MEM_BLOCKS];

    // Cycles seen with req high since the request started
    logic [$clog2(vsmem_pkg::MEM_LATENCY+1)-1:0] lat_cnt;
    // Last latency cycle, access happens here
    logic                                        lat_done;

    assign lat_done = (int'(lat_cnt) == vsmem_pkg::MEM_LATENCY - 1);

    ////////////////////////////////////////
    // Array and handshake
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_ack <= 1'b0;
            lat_cnt <= '0;
            // Contents start at zero
            for (int i = 0; i < vsmem_pkg::MEM_BLOCKS; i++) begin
                mem_array[i] <= '0;
            end
        end else if (mem_ack) begin
            // Ack falls once req is seen low
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req) begin
            if (lat_done) begin
                mem_ack <= 1'b1;
                lat_cnt <= '0;
                if (mem_req_pl.write) begin
                    for (int b = 0; b < 8; b++) begin
                        if (mem_req_pl.byte_en[b]) begin
                            mem_array[mem_req_pl.block_idx].double[8*b +: 8] <=
                                mem_req_pl.wdata.double[8*b +: 8];
                        end
                    end
                end
            end else begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    // Read data valid from ack rise onward
    always_ff @(posedge clock) begin
        if (mem_req && !mem_ack && lat_done && !mem_req_pl.write) begin
            mem_rdata <= mem_array[mem_req_pl.block_idx];
        end
    end

endmodule

// File: verilog/vsmem_top.sv
// Memory side of the front end, fetch and load/store sharing one block memory
`timescale 1ns/100ps

module vsmem_top (
    input  logic                     clock,
    input  logic                     reset,
    input  vsmem_pkg::redirect_t     redirect,
    output vsmem_pkg::fetch_packet_t fetch_out,
    input  logic                     fetch_ready,
    input  logic                     dreq,
    input  vsmem_pkg::dmem_cmd_t     dcmd,
    output logic                     dack,
    output logic [63:0]              drdata
);

    ////////////////////////////////////////
    // Client links
    ////////////////////////////////////////

    logic                  fetch_req;
    vsmem_pkg::mem_req_t   fetch_req_pl;
    logic                  fetch_ack;

    logic                  data_req;
    vsmem_pkg::mem_req_t   data_req_pl;
    logic                  data_ack;

    // Memory link, read data goes straight to both clients
    logic                  mem_req;
    vsmem_pkg::mem_req_t   mem_req_pl;
    logic                  mem_ack;
    vsmem_pkg::mem_block_u mem_rdata;

    fetch_unit fetch_unit_i (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .fetch_out    (fetch_out),
        .fetch_ready  (fetch_ready),
        .fetch_req    (fetch_req),
        .fetch_req_pl (fetch_req_pl),
        .fetch_ack    (fetch_ack),
        .rdata        (mem_rdata)
    );

    data_port data_port_i (
        .clock       (clock),
        .reset       (reset),
        .dreq        (dreq),
        .dcmd        (dcmd),
        .dack        (dack),
        .drdata      (drdata),
        .data_req    (data_req),
        .data_req_pl (data_req_pl),
        .data_ack    (data_ack),
        .rdata       (mem_rdata)
    );

    // Data side has priority
    mem_arbiter mem_arbiter_i (
        .clock        (clock),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_req_pl (fetch_req_pl),
        .fetch_ack    (fetch_ack),
        .data_req     (data_req),
        .data_req_pl  (data_req_pl),
        .data_ack     (data_ack),
        .mem_req      (mem_req),
        .mem_req_pl   (mem_req_pl),
        .mem_ack      (mem_ack)
    );

    block_memory block_memory_i (
        .clock      (clock),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_req_pl (mem_req_pl),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

endmodule

// File: tests/vsmem_assert_assert.sv
// Arbiter handshake checker bound into every mem_arbiter instance
`timescale 1ns/100ps

module vsmem_assert (
    input logic                clock,
    input logic                reset,
    input logic                fetch_req,
    input logic                fetch_ack,
    input logic                data_req,
    input logic                data_ack,
    input logic                mem_req,
    input vsmem_pkg::mem_req_t mem_req_pl,
    input logic                mem_ack,
    input logic                grant_valid
);

    // Only the owner ever sees ack, and ownership never flips from one ack to the next
    assert property (@(posedge clock) disable iff (reset)
        !(fetch_ack && data_ack) &&
        !(fetch_ack && $past(data_ack)) &&
        !(data_ack && $past(fetch_ack)))
        else $error("fetch_ack and data_ack high together or back to back");

    // Memory request and memory ack only under a held grant
    assert property (@(posedge clock) disable iff (reset) mem_req || mem_ack |-> grant_valid)
        else $error("mem_req or mem_ack high without a grant");

    // Ack stays at most one cycle past req drop
    assert property (@(posedge clock) disable iff (reset)
        fetch_ack |-> fetch_req || $past(fetch_req))
        else $error("fetch_ack high without fetch_req");

    assert property (@(posedge clock) disable iff (reset)
        data_ack |-> data_req || $past(data_req))
        else $error("data_ack high without data_req");

    // Payload held for the whole request phase
    assert property (@(posedge clock) disable iff (reset)
        mem_req && $past(mem_req) |-> $stable(mem_req_pl))
        else $error("mem_req_pl changed while mem_req high");

endmodule

bind mem_arbiter vsmem_assert vsmem_assert_i (
    .clock       (clock),
    .reset       (reset),
    .fetch_req   (fetch_req),
    .fetch_ack   (fetch_ack),
    .data_req    (data_req),
    .data_ack    (data_ack),
    .mem_req     (mem_req),
    .mem_req_pl  (mem_req_pl),
    .mem_ack     (mem_ack),
    .grant_valid (grant_valid)
);

// File: tests/vsmem_tb.sv
// Directed testbench for the shared fetch and load/store memory subsystem
`timescale 1ns/100ps

module vsmem_tb;

    logic                     clock = 1'b0;
    logic                     reset;
    vsmem_pkg::redirect_t     redirect;
    vsmem_pkg::fetch_packet_t fetch_out;
    logic                     fetch_ready;
    logic                     dreq;
    vsmem_pkg::dmem_cmd_t     dcmd;
    logic                     dack;
    logic [63:0]              drdata;

    // Byte-wide reference image of the memory
    logic [7:0] ref_mem [256];
    int         errors = 0;
    int         num_checks = 0;
    int         num_rand_ops = 40;
    // Directed data ops plus consumes and redirects
    int         num_directed_ops = 40;
    // Own transaction plus one fetch transaction ahead of it
    int         worst_op_cycles = 32;
    int         watchdog_cycles;
    logic       ops_done;

    vsmem_top vsmem_top_i (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .fetch_out   (fetch_out),
        .fetch_ready (fetch_ready),
        .dreq        (dreq),
        .dcmd        (dcmd),
        .dack        (dack),
        .drdata      (drdata)
    );

    // 40 ns period
    always #20 clock = ~clock;

    ////////////////////////////////////////
    // Reference model and reporting
    ////////////////////////////////////////

    function automatic vsmem_pkg::addr_t align_addr(vsmem_pkg::mem_size_e size,
                                                     vsmem_pkg::addr_t addr);
        return addr & ~vsmem_pkg::addr_t'((1 << size) - 1);
    endfunction

    function automatic logic [63:0] model_load(vsmem_pkg::mem_size_e size,
                                               vsmem_pkg::addr_t addr);
        logic [63:0]      value;
        vsmem_pkg::addr_t base;
        value = '0;
        base  = align_addr(size, addr);
        // Little endian with zero above the size
        for (int i = 0; i < (1 << size); i++) begin
            value[8*i +: 8] = ref_mem[base + i];
        end
        return value;
    endfunction

    task automatic model_store(input vsmem_pkg::mem_size_e size, input vsmem_pkg::addr_t addr,
                               input logic [63:0] data);
        vsmem_pkg::addr_t base;
        base = align_addr(size, addr);
        for (int i = 0; i < (1 << size); i++) begin
            ref_mem[base + i] = data[8*i +: 8];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    // Full four-phase exchange on the outside data link
    task automatic run_data_op(input vsmem_pkg::mem_cmd_e cmd, input vsmem_pkg::mem_size_e size,
                               input vsmem_pkg::addr_t addr, input logic [63:0] data,
                               output logic [63:0] rdata);
        @(negedge clock);
        dcmd.cmd  = cmd;
        dcmd.size = size;
        dcmd.addr = addr;
        dcmd.data = data;
        dreq      = 1'b1;
        @(negedge clock);
        while (dack !== 1'b1) @(negedge clock);
        rdata = drdata;
        dreq  = 1'b0;
        @(negedge clock);
        while (dack !== 1'b0) @(negedge clock);
    endtask

    task automatic store_data(input vsmem_pkg::mem_size_e size, input vsmem_pkg::addr_t addr,
                              input logic [63:0] data);
        logic [63:0] unused;
        run_data_op(vsmem_pkg::STORE, size, addr, data, unused);
        model_store(size, addr, data);
    endtask

    task automatic load_and_check(input vsmem_pkg::mem_size_e size,
                                  input vsmem_pkg::addr_t addr);
        logic [63:0] rdata;
        logic [63:0] expected;
        run_data_op(vsmem_pkg::LOAD, size, addr, '0, rdata);
        expected = model_load(size, addr);
        num_checks++;
        if (rdata !== expected) report_mismatch("drdata", expected, rdata);
    endtask

    // Wait for a packet and check it before one ready cycle takes it
    task automatic consume_inst(input vsmem_pkg::addr_t exp_pc);
        logic [31:0] exp_inst;
        @(negedge clock);
        while (fetch_out.valid !== 1'b1) @(negedge clock);
        exp_inst = 32'(model_load(vsmem_pkg::WORD, exp_pc));
        num_checks++;
        if (fetch_out.pc !== exp_pc) report_mismatch("fetch_out.pc", exp_pc, fetch_out.pc);
        if (fetch_out.inst !== exp_inst) report_mismatch("fetch_out.inst", exp_inst,
                                                         fetch_out.inst);
        fetch_ready = 1'b1;
        @(negedge clock);
        fetch_ready = 1'b0;
    endtask

    // Redirect valid for exactly one sampling edge
    task automatic apply_redirect(input vsmem_pkg::addr_t target);
        @(negedge clock);
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(negedge clock);
        redirect = '0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        num_checks++;
        if (dack !== 1'b0) report_mismatch("dack", 64'h0, dack);
        if (fetch_out.valid !== 1'b0) report_mismatch("fetch_out.valid", 64'h0, fetch_out.valid);
        // First packet held with ready low
        while (fetch_out.valid !== 1'b1) @(negedge clock);
        if (fetch_out.pc !== 8'h00) report_mismatch("fetch_out.pc", 64'h0, fetch_out.pc);
        if (fetch_out.inst !== 32'h0) report_mismatch("fetch_out.inst", 64'h0, fetch_out.inst);
    endtask

    task automatic test_double_roundtrip();
        store_data(vsmem_pkg::DOUBLE, 8'h10, 64'h0123_4567_89ab_cdef);
        load_and_check(vsmem_pkg::DOUBLE, 8'h10);
    endtask

    task automatic test_sized_access();
        store_data(vsmem_pkg::DOUBLE, 8'h20, 64'h0);
        // Upper data bits must be ignored
        store_data(vsmem_pkg::BYTE, 8'h21, 64'hffff_ffff_ffff_ffaa);
        store_data(vsmem_pkg::HALF, 8'h23, 64'h5555_5555_5555_bbcc);
        store_data(vsmem_pkg::WORD, 8'h26, 64'h9999_9999_1122_3344);
        store_data(vsmem_pkg::BYTE, 8'h2f, 64'h0000_0000_0000_0077);
        load_and_check(vsmem_pkg::DOUBLE, 8'h20);
        load_and_check(vsmem_pkg::BYTE, 8'h21);
        load_and_check(vsmem_pkg::HALF, 8'h23);
        load_and_check(vsmem_pkg::WORD, 8'h25);
        load_and_check(vsmem_pkg::WORD, 8'h2c);
        load_and_check(vsmem_pkg::DOUBLE, 8'h2b);
    endtask

    task automatic test_fetch_stream();
        for (int i = 0; i < 6; i++) begin
            store_data(vsmem_pkg::WORD, vsmem_pkg::addr_t'(4 * i), {32'h0, $urandom});
        end
        // Old packet at pc 0 is stale and gets refetched
        apply_redirect(8'h00);
        for (int i = 0; i < 6; i++) begin
            consume_inst(vsmem_pkg::addr_t'(4 * i));
        end
    endtask

    task automatic test_redirect_backpressure();
        // Nonzero word at the target tells its block apart from cleared memory
        store_data(vsmem_pkg::WORD, 8'h40, 64'h0000_0000_a5c3_0f40);
        @(negedge clock);
        while (fetch_out.valid !== 1'b1) @(negedge clock);
        apply_redirect(8'h40);
        num_checks++;
        if (fetch_out.valid !== 1'b0) report_mismatch("fetch_out.valid", 64'h0, fetch_out.valid);
        consume_inst(8'h40);
    endtask

    task automatic test_random_mixed();
        vsmem_pkg::addr_t next_pc;
        int               transfers;
        logic [31:0]      r;
        logic [63:0]      data;
        next_pc   = 8'h80;
        transfers = 0;
        ops_done  = 1'b0;
        apply_redirect(8'h80);
        fork
            begin
                for (int i = 0; i < num_rand_ops; i++) begin
                    r    = $urandom;
                    data = {$urandom, $urandom};
                    if (r[10]) begin
                        store_data(vsmem_pkg::mem_size_e'(r[1:0]), r[9:2], data);
                    end else begin
                        load_and_check(vsmem_pkg::mem_size_e'(r[1:0]), r[9:2]);
                    end
                end
                ops_done = 1'b1;
            end
            begin
                // Stream with ready high and one valid cycle per packet
                fetch_ready = 1'b1;
                forever begin
                    @(negedge clock);
                    if (ops_done) begin
                        fetch_ready = 1'b0;
                        break;
                    end
                    if (fetch_out.valid === 1'b1) begin
                        num_checks++;
                        if (fetch_out.pc !== next_pc) begin
                            report_mismatch("fetch_out.pc", next_pc, fetch_out.pc);
                        end
                        next_pc = next_pc + vsmem_pkg::addr_t'(4);
                        transfers++;
                    end
                end
            end
        join
        if (transfers == 0) report_error("fetch made no progress while loads and stores ran");
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset       = 1'b1;
        redirect    = '0;
        fetch_ready = 1'b0;
        dreq        = 1'b0;
        dcmd        = '0;
        ops_done    = 1'b0;
        void'($urandom(32'h1758));
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (3) @(negedge clock);
        reset = 1'b0;
        test_reset_state();
        test_double_roundtrip();
        test_sized_access();
        test_fetch_stream();
        test_redirect_backpressure();
        test_random_mixed();
        repeat (4) @(negedge clock);
        $display("Checks run: %0d, errors: %0d", num_checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        watchdog_cycles = (num_directed_ops + num_rand_ops) * worst_op_cycles + 200;
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: vsmem.f
verilog/vsmem_pkg.sv
verilog/fetch_unit.sv
verilog/data_port.sv
verilog/mem_arbiter.sv
verilog/block_memory.sv
verilog/vsmem_top.sv
tests/vsmem_assert_assert.sv
tests/vsmem_tb.sv

// File: Bender.yml
package:
  name: vsmem

sources:
  - files:
      - verilog/vsmem_pkg.sv
      - verilog/fetch_unit.sv
      - verilog/data_port.sv
      - verilog/mem_arbiter.sv
      - verilog/block_memory.sv
      - verilog/vsmem_top.sv
  - target: test
    files:
      - tests/vsmem_assert_assert.sv
      - tests/vsmem_tb.sv
